// ==== verilog.f ====
src/mem_cfg_pkg.sv
src/mem_types_pkg.sv
src/mem_port_front.sv
src/byte_lane_ram.sv
src/read_word_merge.sv
src/unified_mem_top.sv
verification/unified_mem_checker.sv
verification/unified_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the unified memory testbench with Verilator, run it and scan the log.

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module unified_mem_tb \
	-Mdir obj_dir -o unified_mem_sim > sim.log 2>&1 \
	&& ./obj_dir/unified_mem_sim >> sim.log 2>&1 \
	|| { echo "build or simulation error, see sim.log"; exit 1; }

grep -q "Test failures found" sim.log \
	&& { echo "simulation FAILED, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// ==== verification/unified_mem_tb.sv ====
// unified memory testbench
// table driven directed tests, then a random mixed phase, checker does the comparing

`timescale 1ns/10ps

module unified_mem_tb
	import mem_cfg_pkg::*;
	import mem_types_pkg::*;
();

	typedef enum logic [2:0] {
		OP_IDLE,
		OP_FETCH,
		OP_LOAD,
		OP_STORE,
		OP_BOTH,
		OP_STORE_FETCH
	} op_t;

	// one table row, exp is the read word and waits the expected wait cycles
	typedef struct packed {
		op_t        op;
		addr_t      addr;
		word_t      wd;
		mask_t      mask;
		word_t      exp;
		logic [3:0] waits;
	} stim_t;

	localparam int NUM_STIM   = 21;
	localparam int WAIT_LIMIT = 20;
	localparam int RAND_OPS   = 200;

	logic       Bus;
	logic       arst_n;
	fetch_req_t imem;
	data_req_t  dmem;
	word_t      imem_instn;
	word_t      dmem_rd;
	logic       imem_wait;
	logic       dmem_wait;
	logic       exp_on;
	logic       exp_rd;
	word_t      exp_word;
	int         exp_waits;
	int         errors;
	int         checks;
	logic       timed_out;
	int         err_before;
	stim_t      stim [NUM_STIM];

	initial Bus = 1'b0;
	always #10 Bus = ~Bus;

	unified_mem_top DUT (
		.Bus        (Bus),
		.arst_n     (arst_n),
		.imem       (imem),
		.imem_instn (imem_instn),
		.imem_wait  (imem_wait),
		.dmem       (dmem),
		.dmem_rd    (dmem_rd),
		.dmem_wait  (dmem_wait)
	);

	unified_mem_checker u_checker (
		.Bus        (Bus),
		.arst_n     (arst_n),
		.imem       (imem),
		.imem_instn (imem_instn),
		.imem_wait  (imem_wait),
		.dmem       (dmem),
		.dmem_rd    (dmem_rd),
		.dmem_wait  (dmem_wait),
		.exp_on     (exp_on),
		.exp_rd     (exp_rd),
		.exp_word   (exp_word),
		.exp_waits  (exp_waits),
		.errors     (errors),
		.checks     (checks)
	);

	function automatic stim_t make_entry(op_t op, addr_t addr, word_t wd, mask_t mask,
		word_t exp, int waits);
		stim_t s;
		s.op    = op;
		s.addr  = addr;
		s.wd    = wd;
		s.mask  = mask;
		s.exp   = exp;
		s.waits = waits[3:0];
		return s;
	endfunction

	// addresses with bits 3..2 = 11 take two wait cycles
	task automatic fill_stim();
		// full store, then partial masks merge into it
		stim[0]  = make_entry(OP_STORE, 32'h100, 32'h11223344, 4'hf, 32'h0, 0);
		stim[1]  = make_entry(OP_LOAD, 32'h100, 32'h0, 4'h0, 32'h11223344, 0);
		stim[2]  = make_entry(OP_STORE, 32'h100, 32'haabbccdd, 4'h5, 32'h0, 0);
		stim[3]  = make_entry(OP_LOAD, 32'h100, 32'h0, 4'h0, 32'h11bb33dd, 0);
		stim[4]  = make_entry(OP_STORE, 32'h100, 32'h99887766, 4'h8, 32'h0, 0);
		stim[5]  = make_entry(OP_LOAD, 32'h100, 32'h0, 4'h0, 32'h99bb33dd, 0);
		// fetch port sees the same array, also in the same cycle as a load
		stim[6]  = make_entry(OP_FETCH, 32'h100, 32'h0, 4'h0, 32'h99bb33dd, 0);
		stim[7]  = make_entry(OP_BOTH, 32'h100, 32'h0, 4'h0, 32'h99bb33dd, 0);
		// slow word at 0x10c
		stim[8]  = make_entry(OP_STORE, 32'h10c, 32'hcafef00d, 4'hf, 32'h0, 2);
		stim[9]  = make_entry(OP_LOAD, 32'h10c, 32'h0, 4'h0, 32'hcafef00d, 2);
		stim[10] = make_entry(OP_FETCH, 32'h10c, 32'h0, 4'h0, 32'hcafef00d, 2);
		stim[11] = make_entry(OP_STORE, 32'h10c, 32'h0000ab00, 4'h2, 32'h0, 2);
		stim[12] = make_entry(OP_BOTH, 32'h10c, 32'h0, 4'h0, 32'hcafeab0d, 2);
		// held store next to a fetch of the same slow word
		// the fetch still sees the old word when both complete
		stim[13] = make_entry(OP_STORE_FETCH, 32'h10c, 32'h00ef0000, 4'h4, 32'hcafeab0d, 2);
		stim[14] = make_entry(OP_LOAD, 32'h10c, 32'h0, 4'h0, 32'hcaefab0d, 2);
		// aliasing, bits above the word index are ignored
		stim[15] = make_entry(OP_STORE, 32'h204, 32'h12345678, 4'hf, 32'h0, 0);
		stim[16] = make_entry(OP_LOAD, 32'h1204, 32'h0, 4'h0, 32'h12345678, 0);
		stim[17] = make_entry(OP_FETCH, 32'h3204, 32'h0, 4'h0, 32'h12345678, 0);
		stim[18] = make_entry(OP_STORE, 32'h1208, 32'hdeadbeef, 4'hf, 32'h0, 0);
		stim[19] = make_entry(OP_LOAD, 32'h208, 32'h0, 4'h0, 32'hdeadbeef, 0);
		stim[20] = make_entry(OP_IDLE, 32'h0, 32'h0, 4'h0, 32'h0, 0);
	endtask

	// set both request structs for one operation
	task automatic drive_port(op_t op, addr_t addr, word_t wd, mask_t mask);
		imem = '0;
		dmem = '0;
		if (op == OP_FETCH || op == OP_BOTH || op == OP_STORE_FETCH) begin
			imem.addr = addr;
			imem.req  = 1'b1;
		end
		if (op == OP_LOAD || op == OP_STORE || op == OP_BOTH || op == OP_STORE_FETCH) begin
			dmem.addr = addr;
			dmem.req  = 1'b1;
		end
		if (op == OP_STORE || op == OP_STORE_FETCH) begin
			dmem.we   = 1'b1;
			dmem.wd   = wd;
			dmem.mask = mask;
		end
	endtask

	// hold the request until wait drops, then one idle cycle
	task automatic run_op(op_t op, addr_t addr, word_t wd, mask_t mask, output logic ok);
		int cycles;
		cycles = 0;
		ok     = 1'b1;
		drive_port(op, addr, wd, mask);
		@(negedge Bus);
		while ((imem_wait || dmem_wait) && ok) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("wait stayed high for more than %0d cycles at address %h",
					WAIT_LIMIT, addr);
				ok = 1'b0;
			end
			@(negedge Bus);
		end
		@(posedge Bus);
		#2;
		drive_port(OP_IDLE, '0, '0, '0);
		@(posedge Bus);
		#2;
	endtask

	task automatic report_test(string name, int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	initial begin
		logic  ok;
		op_t   r_op;
		addr_t r_addr;
		word_t r_wd;
		mask_t r_mask;
		void'($urandom(32'h6fac9c54));
		arst_n    = 1'b0;
		imem      = '0;
		dmem      = '0;
		exp_on    = 1'b0;
		exp_rd    = 1'b0;
		exp_word  = '0;
		exp_waits = 0;
		timed_out = 1'b0;
		ok        = 1'b1;
		fill_stim();
		repeat (5) @(posedge Bus);
		#2;
		arst_n = 1'b1;
		// both ports idle, waits low and read words zero
		err_before = errors;
		repeat (2) @(posedge Bus);
		#2;
		report_test("reset idle", err_before);
		for (int n = 0; n < NUM_STIM && !timed_out; n++) begin
			err_before = errors;
			exp_on     = 1'b1;
			exp_rd     = stim[n].op inside {OP_FETCH, OP_LOAD, OP_BOTH, OP_STORE_FETCH};
			exp_word   = stim[n].exp;
			exp_waits  = int'(stim[n].waits);
			run_op(stim[n].op, stim[n].addr, stim[n].wd, stim[n].mask, ok);
			exp_on = 1'b0;
			if (!ok)
				timed_out = 1'b1;
			report_test($sformatf("%0d %s %h", n, stim[n].op.name(), stim[n].addr), err_before);
		end
		// random mix over 32 words with random alias bits
		if (!timed_out) begin
			err_before = errors;
			for (int n = 0; n < RAND_OPS && ok; n++) begin
				r_op   = op_t'($urandom_range(5, 1));
				r_addr = ($urandom() & 32'hffff_f000) | (($urandom() % 32) << 2);
				r_wd   = $urandom();
				r_mask = mask_t'($urandom_range(15, 0));
				run_op(r_op, r_addr, r_wd, r_mask, ok);
			end
			if (!ok)
				timed_out = 1'b1;
			report_test("random mix", err_before);
		end
		$display("summary: %0d checks, %0d errors%s", checks, errors,
			timed_out ? ", stopped by a wait timeout" : "");
		if (errors == 0 && !timed_out) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule : unified_mem_tb

// ==== verification/unified_mem_checker.sv ====
// unified memory checker
// shadow memory plus its own miss model, compares every DUT read and wait level

`timescale 1ns/10ps

module unified_mem_checker
	import mem_cfg_pkg::*;
	import mem_types_pkg::*;
(
	input  logic       Bus,
	input  logic       arst_n,
	input  fetch_req_t imem,
	input  word_t      imem_instn,
	input  logic       imem_wait,
	input  data_req_t  dmem,
	input  word_t      dmem_rd,
	input  logic       dmem_wait,
	// expectations from the stimulus table
	input  logic       exp_on,
	input  logic       exp_rd,
	input  word_t      exp_word,
	input  int         exp_waits,
	output int         errors,
	output int         checks
);

	localparam int DEPTH = 1 << WORD_IDX_W;

	// shadow words and which of their bytes have ever been written
	word_t shadow [DEPTH];
	mask_t known  [DEPTH];

	// model states: 0 idle, 1 first miss cycle, 2 recover
	int i_st;
	int d_st;
	// wait cycles seen so far by the pending request of each port
	int i_wcnt;
	int d_wcnt;

	initial begin
		errors = 0;
		checks = 0;
		i_st   = 0;
		d_st   = 0;
		i_wcnt = 0;
		d_wcnt = 0;
		for (int k = 0; k < DEPTH; k++) begin
			known[k] = '0;
		end
	end

	// wait level this cycle
	function automatic logic model_wait(int st, logic req, addr_t addr);
		if (st == 1)
			return 1'b1;
		if (st == 2)
			return 1'b0;
		return req && (addr[3:2] == SLOW_PAT);
	endfunction

	// state after the next rising edge
	function automatic int model_next(int st, logic req, addr_t addr);
		if (st == 1)
			return 2;
		if (st == 2)
			return 0;
		return (req && (addr[3:2] == SLOW_PAT)) ? 1 : 0;
	endfunction

	task automatic cmp_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic cmp_count(string name, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	// only bytes that were written are compared, the array starts empty
	task automatic cmp_read(string name, word_t got, addr_t addr);
		word_idx_t w;
		word_t     bmask;
		w = addr[WORD_IDX_W+1:2];
		for (int b = 0; b < LANES; b++) begin
			bmask[b*8 +: 8] = {8{known[w][b]}};
		end
		cmp_word(name, got & bmask, shadow[w] & bmask);
		if (exp_on && exp_rd) begin
			cmp_word({name, " (table)"}, got, exp_word);
		end
	endtask

	// byte mask rule, one byte per set bit
	task automatic apply_store(addr_t addr, word_t wd, mask_t mask);
		word_idx_t w;
		w = addr[WORD_IDX_W+1:2];
		for (int b = 0; b < LANES; b++) begin
			if (mask[b]) begin
				shadow[w][b*8 +: 8] = wd[b*8 +: 8];
				known[w][b] = 1'b1;
			end
		end
	endtask

	// mid cycle, inputs and combinational outputs are settled
	always @(negedge Bus) begin
		logic i_wexp;
		logic d_wexp;
		if (!arst_n) begin
			i_st   = 0;
			d_st   = 0;
			i_wcnt = 0;
			d_wcnt = 0;
		end
		i_wexp = model_wait(i_st, imem.req, imem.addr);
		d_wexp = model_wait(d_st, dmem.req, dmem.addr);
		cmp_word("imem_wait", {31'b0, imem_wait}, {31'b0, i_wexp});
		cmp_word("dmem_wait", {31'b0, dmem_wait}, {31'b0, d_wexp});
		// idle ports read back zero
		if (!imem.req)
			cmp_word("imem_instn", imem_instn, '0);
		if (!dmem.req)
			cmp_word("dmem_rd", dmem_rd, '0);
		// fetch completes, compared before this cycle's store lands
		if (imem.req && !i_wexp) begin
			cmp_read("imem_instn", imem_instn, imem.addr);
			if (exp_on)
				cmp_count("imem wait cycles", i_wcnt, exp_waits);
			i_wcnt = 0;
		end else if (imem.req) begin
			i_wcnt++;
		end
		// data port completes
		if (dmem.req && !d_wexp) begin
			if (!dmem.we)
				cmp_read("dmem_rd", dmem_rd, dmem.addr);
			if (exp_on)
				cmp_count("dmem wait cycles", d_wcnt, exp_waits);
			if (dmem.we)
				apply_store(dmem.addr, dmem.wd, dmem.mask);
			d_wcnt = 0;
		end else if (dmem.req) begin
			d_wcnt++;
		end
		if (arst_n) begin
			i_st = model_next(i_st, imem.req, imem.addr);
			d_st = model_next(d_st, dmem.req, dmem.addr);
		end
	end

endmodule : unified_mem_checker

// ==== src/unified_mem_top.sv ====
// unified memory top level
// fetch port and masked data port over one shared array of byte lanes

`timescale 1ns/10ps

module unified_mem_top
	import mem_cfg_pkg::*;
	import mem_types_pkg::*;
(
	input  logic       Bus,
	input  logic       arst_n,

	// instruction fetch port
	input  fetch_req_t imem,
	output word_t      imem_instn,
	output logic       imem_wait,

	// data port
	input  data_req_t  dmem,
	output word_t      dmem_rd,
	output logic       dmem_wait
);

	// one command and one read pair per lane
	lane_cmd_t [LANES-1:0] lane_cmd;
	lane_rd_t  [LANES-1:0] lane_rd;

	// request capture, miss models and lane commands
	mem_port_front u_front (
		.Bus       (Bus),
		.arst_n    (arst_n),
		.imem      (imem),
		.dmem      (dmem),
		.lane_cmd  (lane_cmd),
		.imem_wait (imem_wait),
		.dmem_wait (dmem_wait)
	);

	// the shared word array, split into byte lanes
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		byte_lane_ram u_lane (
			.Bus (Bus),
			.cmd (lane_cmd[i]),
			.rd  (lane_rd[i])
		);
	end

	// lane bytes back into words, gated by request
	read_word_merge u_merge (
		.lane_rd    (lane_rd),
		.imem_req   (imem.req),
		.dmem_req   (dmem.req),
		.imem_instn (imem_instn),
		.dmem_rd    (dmem_rd)
	);

endmodule : unified_mem_top

// ==== src/read_word_merge.sv ====
// read word merge
// packs the lane bytes into fetch and load words, zero while a port is idle

`timescale 1ns/10ps

module read_word_merge
	import mem_types_pkg::*;
(
	input  lane_rd_t [$bits(mask_t)-1:0] lane_rd,
	input  logic                         imem_req,
	input  logic                         dmem_req,
	output word_t                        imem_instn,
	output word_t                        dmem_rd
);

	// one lane per mask bit, one byte per lane
	localparam int NL = $bits(mask_t);
	localparam int BW = $bits(byte_t);

	word_t fetch_word;
	word_t load_word;

	// lane i sits at bits 8i+7..8i
	always_comb begin
		for (int i = 0; i < NL; i++) begin
			fetch_word[i*BW +: BW] = lane_rd[i].fetch_byte;
			load_word[i*BW +: BW]  = lane_rd[i].load_byte;
		end
	end

	// a port with no request reads back zero
	assign imem_instn = imem_req ? fetch_word : '0;
	assign dmem_rd    = dmem_req ? load_word : '0;

	// fetch word must be clear whenever fetch is idle
	always_comb begin
		a_instn_zero_idle: assert #0 (imem_req || (imem_instn == '0));
	end

endmodule : read_word_merge

// ==== src/byte_lane_ram.sv ====
// byte lane RAM
// one byte of every word, two combinational read ports and one write port

`timescale 1ns/10ps

module byte_lane_ram
	import mem_types_pkg::*;
(
	input  logic      Bus,
	input  lane_cmd_t cmd,
	output lane_rd_t  rd
);

	// one entry per word index
	localparam int DEPTH = 2 ** $bits(word_idx_t);

	// storage for this lane, contents are whatever was last written
	byte_t mem [DEPTH];

	// fetch read path
	// reads the array before any same cycle write lands, so it sees the old byte
	assign rd.fetch_byte = mem[cmd.fetch_idx];

	// load read path
	assign rd.load_byte = mem[cmd.load_idx];

	// write lands on the rising edge
	// the enable already folds in mask bit, store and wait
	always_ff @(posedge Bus) begin
		if (cmd.we) begin
			mem[cmd.wr_idx] <= cmd.wr_byte;
		end
	end

	// no X may be written into the array
	a_wr_byte_known: assert property (@(posedge Bus)
		cmd.we |-> !$isunknown(cmd.wr_byte));

	// write index must be clean as well, or a random word gets hit
	a_wr_idx_known: assert property (@(posedge Bus)
		cmd.we |-> !$isunknown(cmd.wr_idx));

endmodule : byte_lane_ram

// ==== src/mem_port_front.sv ====
// memory port front end
// runs one miss model per port and turns the two requests into per lane commands

`timescale 1ns/10ps

module mem_port_front
	import mem_cfg_pkg::*;
	import mem_types_pkg::*;
(
	input  logic                   Bus,
	input  logic                   arst_n,
	input  fetch_req_t             imem,
	input  data_req_t              dmem,
	output lane_cmd_t [LANES-1:0]  lane_cmd,
	output logic                   imem_wait,
	output logic                   dmem_wait
);

	miss_state_t imem_state, imem_state_nxt;
	miss_state_t dmem_state, dmem_state_nxt;
	word_idx_t   fetch_idx;
	word_idx_t   load_idx;
	logic        store_ok;

	// true when a live request targets the slow address pattern
	function automatic logic slow_req(logic req, addr_t addr);
		return req && (addr[3:2] == SLOW_PAT);
	endfunction

	// mealy wait output of the miss model
	function automatic logic miss_wait(miss_state_t st, logic req, addr_t addr);
		logic w;
		case (st)
			IDLE:    w = slow_req(req, addr);
			MISS1:   w = 1'b1;
			default: w = 1'b0;
		endcase
		return w;
	endfunction

	// next state of the miss model
	function automatic miss_state_t miss_next(miss_state_t st, logic req, addr_t addr);
		miss_state_t nxt;
		case (st)
			IDLE:    nxt = slow_req(req, addr) ? MISS1 : IDLE;
			MISS1:   nxt = RECOVER;
			// held request completes here, then back to idle
			default: nxt = IDLE;
		endcase
		return nxt;
	endfunction

	// each port has its own copy of the model
	assign imem_wait      = miss_wait(imem_state, imem.req, imem.addr);
	assign dmem_wait      = miss_wait(dmem_state, dmem.req, dmem.addr);
	assign imem_state_nxt = miss_next(imem_state, imem.req, imem.addr);
	assign dmem_state_nxt = miss_next(dmem_state, dmem.req, dmem.addr);

	always_ff @(posedge Bus or negedge arst_n) begin
		if (!arst_n) begin
			imem_state <= IDLE;
			dmem_state <= IDLE;
		end else begin
			imem_state <= imem_state_nxt;
			dmem_state <= dmem_state_nxt;
		end
	end

	// word index, bits above it alias
	assign fetch_idx = imem.addr[WORD_IDX_W+1:2];
	assign load_idx  = dmem.addr[WORD_IDX_W+1:2];

	// a store only commits in its completing cycle
	assign store_ok = dmem.req && dmem.we && !dmem_wait;

	// fan the data port out to the byte lanes
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lane_cmd[i].fetch_idx = fetch_idx;
			lane_cmd[i].load_idx  = load_idx;
			lane_cmd[i].wr_idx    = load_idx;
			lane_cmd[i].wr_byte   = dmem.wd[i*BYTE_W +: BYTE_W];
			lane_cmd[i].we        = store_ok && dmem.mask[i];
		end
	end

	// a miss never stretches past its wait budget
	a_imem_wait_len: assert property (@(posedge Bus) disable iff (!arst_n)
		imem_wait [*MISS_WAIT_CYC] |=> !imem_wait);
	a_dmem_wait_len: assert property (@(posedge Bus) disable iff (!arst_n)
		dmem_wait [*MISS_WAIT_CYC] |=> !dmem_wait);

	// idle port with no request never stalls
	a_imem_idle_nowait: assert property (@(posedge Bus) disable iff (!arst_n)
		(imem_state == IDLE && !imem.req) |-> !imem_wait);
	a_dmem_idle_nowait: assert property (@(posedge Bus) disable iff (!arst_n)
		(dmem_state == IDLE && !dmem.req) |-> !dmem_wait);

endmodule : mem_port_front

// ==== src/mem_types_pkg.sv ====
// memory types package
// vector types, port request structs, lane structs and the miss model states

package mem_types_pkg;

	import mem_cfg_pkg::*;

	// plain vectors with a meaning
	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [BYTE_W-1:0]     byte_t;
	typedef logic [LANES-1:0]      mask_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// instruction fetch port request
	typedef struct packed {
		addr_t addr;
		logic  req;
	} fetch_req_t;

	// data port request, mask bit i enables byte lane i
	typedef struct packed {
		addr_t addr;
		word_t wd;
		mask_t mask;
		logic  we;
		logic  req;
	} data_req_t;

	// command sent to one byte lane
	typedef struct packed {
		word_idx_t fetch_idx;
		word_idx_t load_idx;
		word_idx_t wr_idx;
		byte_t     wr_byte;
		logic      we;
	} lane_cmd_t;

	// bytes returned from one lane
	typedef struct packed {
		byte_t fetch_byte;
		byte_t load_byte;
	} lane_rd_t;

	// miss model states
	typedef enum logic [1:0] {
		IDLE,
		MISS1,
		RECOVER
	} miss_state_t;

endpackage : mem_types_pkg

// ==== src/mem_cfg_pkg.sv ====
// memory configuration package
// sizes of the unified instruction/data memory and the miss model constants

package mem_cfg_pkg;

	// byte address and data word widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// one lane per byte of a word
	localparam int LANES = 4;
	localparam int BYTE_W = DATA_W / LANES;

	// word index into the array, 1024 words deep
	// upper address bits above the index alias onto the same words
	localparam int WORD_IDX_W = 10;

	// addr[3:2] value that takes the slow path
	localparam logic [1:0] SLOW_PAT = 2'b11;

	// wait cycles that a slow request sees before it completes
	localparam int MISS_WAIT_CYC = 2;

endpackage : mem_cfg_pkg
